//--- src/link_pkg.sv
`default_nettype none

package link_pkg;

    //////////////////////////////
    // words on the link
    //////////////////////////////

    // one float word, used for length, rate and bus data
    typedef logic [31:0] data_word_t;

    // bits in one spi frame
    localparam int FRAME_BITS = 32;
    // bit counter, one bit wider so a long frame shows up
    localparam int BIT_CNT_W = $clog2(FRAME_BITS) + 1;
    // good frames seen by the slave
    localparam int FRAME_CNT_W = 8;

    //////////////////////////////
    // spi fsm states
    //////////////////////////////

    typedef enum logic [1:0] {TX_IDLE, TX_SHIFT, TX_END} tx_state_e;
    typedef enum logic {RX_IDLE, RX_SHIFT} rx_state_e;

endpackage

`default_nettype wire

//--- src/regmap_pkg.sv
`default_nettype none

package regmap_pkg;

    //////////////////////////////
    // host register map
    //////////////////////////////

    // word addresses on the wishbone port
    typedef enum logic [2:0] {
        REG_CTRL      = 3'd0,
        REG_TICK_HALF = 3'd1,
        REG_SCK_DIV   = 3'd2,
        REG_WAVE_DATA = 3'd3,
        REG_RATE_IN   = 3'd4,
        REG_LEN_OUT   = 3'd5,
        REG_STATUS    = 3'd6
    } reg_addr_e;

    // control register fields
    localparam int CTRL_RUN_BIT     = 0;
    // self clearing
    localparam int CTRL_RESTART_BIT = 1;

    // tick period minus one after reset
    localparam logic [31:0] RESET_TICK_HALF = 32'd200;
    // sck half period minus one after reset
    localparam logic [31:0] RESET_SCK_DIV = 32'd13;

endpackage

`default_nettype wire

//--- src/cfg_if.sv
`default_nettype none

// register block settings for the player and the spi master
interface cfg_if import link_pkg::*; ();

    logic       run;
    // one cycle pulses
    logic       restart;
    logic       wave_wr;
    data_word_t tick_half;
    data_word_t wave_data;
    data_word_t sck_div;

    modport regs (output run, restart, tick_half, wave_wr, wave_data, sck_div);
    // waveform side, everything but the sck divider
    modport player (input run, restart, tick_half, wave_wr, wave_data);
    // spi master only needs its divider
    modport serial (input sck_div);

endinterface

`default_nettype wire

//--- src/host_regs.sv
`default_nettype none

module host_regs import link_pkg::*; import regmap_pkg::*;
#(
    parameter int WAVE_DEPTH = 16
)
(
    input  wire logic                             ep50trig,
    input  wire logic                             reset_global,
    input  wire logic                             wb_cyc,
    input  wire logic                             wb_stb,
    input  wire logic                             wb_we,
    input  wire reg_addr_e                        wb_adr,
    input  wire data_word_t                       wb_wdata,
    output data_word_t                            wb_rdata,
    output logic                                  wb_ack,
    input  wire data_word_t                       length,
    input  wire data_word_t                       rate,
    input  wire logic [$clog2(WAVE_DEPTH+1)-1:0]  wave_count,
    input  wire logic [FRAME_CNT_W-1:0]           frame_count,
    cfg_if.regs                                   cfg
);

    // new request, not yet acked
    logic       req_new;
    logic       table_full;
    logic [7:0] status_count;
    data_word_t rd_mux;

    assign req_new      = wb_cyc && wb_stb && !wb_ack;
    assign table_full   = (wave_count == WAVE_DEPTH);
    // sample count squeezed into the low status byte
    assign status_count = 8'(wave_count);

    //////////////////////////////
    // read side
    //////////////////////////////

    always_comb
    begin
        case (wb_adr)
            REG_CTRL:      rd_mux = data_word_t'(cfg.run) << CTRL_RUN_BIT;
            REG_TICK_HALF: rd_mux = cfg.tick_half;
            REG_SCK_DIV:   rd_mux = cfg.sck_div;
            REG_RATE_IN:   rd_mux = rate;
            REG_LEN_OUT:   rd_mux = length;
            REG_STATUS:    rd_mux = data_word_t'({frame_count, status_count});
            // wave data is write only, unmapped reads as zero
            default:       rd_mux = '0;
        endcase
    end

    //////////////////////////////
    // write side and ack
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            wb_ack        <= 1'b0;
            cfg.run       <= 1'b0;
            cfg.restart   <= 1'b0;
            cfg.wave_wr   <= 1'b0;
            cfg.tick_half <= RESET_TICK_HALF;
            cfg.sck_div   <= RESET_SCK_DIV;
        end
        else
        begin
            // single cycle ack, no wait states
            wb_ack      <= req_new;
            cfg.restart <= 1'b0;
            cfg.wave_wr <= 1'b0;
            if (req_new && wb_we)
            begin
                case (wb_adr)
                    REG_CTRL:
                    begin
                        cfg.run     <= wb_wdata[CTRL_RUN_BIT];
                        cfg.restart <= wb_wdata[CTRL_RESTART_BIT];
                    end
                    REG_TICK_HALF: cfg.tick_half <= wb_wdata;
                    REG_SCK_DIV:   cfg.sck_div   <= wb_wdata;
                    // full table drops the sample here
                    REG_WAVE_DATA: cfg.wave_wr   <= !table_full;
                    // read only and unmapped writes fall through
                    default: ;
                endcase
            end
        end
    end

    // data path, captured with the request
    always_ff @(posedge ep50trig)
    begin
        if (req_new)
        begin
            wb_rdata <= rd_mux;
        end
        if (req_new && wb_we && (wb_adr == REG_WAVE_DATA))
        begin
            cfg.wave_data <= wb_wdata;
        end
    end

endmodule

`default_nettype wire

//--- src/length_waveform.sv
`default_nettype none

module length_waveform import link_pkg::*;
#(
    parameter int WAVE_DEPTH = 16
)
(
    input  wire logic                             ep50trig,
    input  wire logic                             reset_global,
    cfg_if.player                                 cfg,
    output logic                                  sample_tick,
    output data_word_t                            length,
    output logic [$clog2(WAVE_DEPTH+1)-1:0]       wave_count
);

    localparam int PTR_W = $clog2(WAVE_DEPTH);
    localparam int CNT_W = $clog2(WAVE_DEPTH + 1);

    data_word_t       table_mem [WAVE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] play_ptr;
    logic [CNT_W-1:0] play_next;
    data_word_t       tick_cnt;
    logic             tick_now;

    // tick at the end of each period while running
    assign tick_now  = cfg.run && (tick_cnt == cfg.tick_half);
    // wrap point is the filled count, not the depth
    assign play_next = CNT_W'(play_ptr) + 1'b1;

    // sample storage
    always_ff @(posedge ep50trig)
    begin
        if (cfg.wave_wr)
        begin
            table_mem[wr_ptr] <= cfg.wave_data;
        end
    end

    //////////////////////////////
    // tick and playback
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            wr_ptr      <= '0;
            play_ptr    <= '0;
            wave_count  <= '0;
            tick_cnt    <= '0;
            sample_tick <= 1'b0;
            length      <= '0;
        end
        else
        begin
            sample_tick <= tick_now;
            // counter parks at zero while stopped
            if (!cfg.run || tick_now)
                tick_cnt <= '0;
            else
                tick_cnt <= tick_cnt + 1'b1;

            if (cfg.restart)
            begin
                wr_ptr     <= '0;
                play_ptr   <= '0;
                wave_count <= '0;
            end
            else if (cfg.wave_wr)
            begin
                // host never pulses wave_wr on a full table
                wr_ptr     <= (wr_ptr == PTR_W'(WAVE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
                wave_count <= wave_count + 1'b1;
            end

            if (tick_now)
            begin
                if (wave_count == '0)
                begin
                    // empty table plays zero
                    length <= '0;
                end
                else
                begin
                    length   <= table_mem[play_ptr];
                    play_ptr <= (play_next >= wave_count) ? '0 : PTR_W'(play_next);
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/spi_frame_tx.sv
`default_nettype none

module spi_frame_tx import link_pkg::*;
(
    input  wire logic       ep50trig,
    input  wire logic       reset_global,
    input  wire logic       sample_tick,
    input  wire data_word_t length,
    cfg_if.serial           cfg,
    output logic            sck,
    output logic            mosi,
    output logic            ssel
);

    tx_state_e              state;
    data_word_t             div_cnt;
    logic [BIT_CNT_W-1:0]   bit_cnt;
    data_word_t             shreg;
    logic                   half_done;

    // one sck level is sck_div+1 cycles
    assign half_done = (div_cnt == cfg.sck_div);

    //////////////////////////////
    // spi master, mode 0
    //////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            state   <= TX_IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
            sck     <= 1'b0;
            mosi    <= 1'b0;
            ssel    <= 1'b1;
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    // ticks during a frame never get here, so they are lost
                    if (sample_tick)
                    begin
                        ssel    <= 1'b0;
                        mosi    <= length[FRAME_BITS-1];
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= TX_SHIFT;
                    end
                end
                TX_SHIFT:
                begin
                    if (!half_done)
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                    else
                    begin
                        div_cnt <= '0;
                        sck     <= !sck;
                        // falling edge, next bit onto mosi
                        if (sck)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == BIT_CNT_W'(FRAME_BITS - 1))
                                state <= TX_END;
                            else
                                mosi <= shreg[FRAME_BITS-2];
                        end
                    end
                end
                TX_END:
                begin
                    // two cycles of ssel low after the last fall
                    if (div_cnt == data_word_t'(1))
                    begin
                        ssel    <= 1'b1;
                        mosi    <= 1'b0;
                        div_cnt <= '0;
                        state   <= TX_IDLE;
                    end
                    else
                    begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                default: state <= TX_IDLE;
            endcase
        end
    end

    // shift register, msb first
    always_ff @(posedge ep50trig)
    begin
        if (state == TX_IDLE && sample_tick)
            shreg <= length;
        else if (state == TX_SHIFT && half_done && sck)
            shreg <= shreg << 1;
    end

endmodule

`default_nettype wire

//--- src/spi_frame_rx.sv
`default_nettype none

module spi_frame_rx import link_pkg::*;
(
    input  wire logic                    ep50trig,
    input  wire logic                    reset_global,
    input  wire logic                    sample_tick,
    input  wire logic                    sck,
    input  wire logic                    mosi,
    input  wire logic                    ssel,
    output data_word_t                   rate,
    output logic [FRAME_CNT_W-1:0]       frame_count
);

    // two sync stages plus one for edge detect
    logic [2:0]           sck_pipe;
    logic [2:0]           ssel_pipe;
    logic [1:0]           mosi_pipe;
    logic                 sck_rise;
    logic                 ssel_rise;
    rx_state_e            state;
    logic [BIT_CNT_W-1:0] bit_cnt;
    data_word_t           shreg;
    // first latch, good word waits here for the tick
    data_word_t           rx_word;

    assign sck_rise  = sck_pipe[1] && !sck_pipe[2];
    assign ssel_rise = ssel_pipe[1] && !ssel_pipe[2];

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            sck_pipe    <= '0;
            ssel_pipe   <= '1;
            mosi_pipe   <= '0;
            state       <= RX_IDLE;
            bit_cnt     <= '0;
            shreg       <= '0;
            rx_word     <= '0;
            rate        <= '0;
            frame_count <= '0;
        end
        else
        begin
            sck_pipe  <= {sck_pipe[1:0], sck};
            ssel_pipe <= {ssel_pipe[1:0], ssel};
            mosi_pipe <= {mosi_pipe[0], mosi};

            case (state)
                RX_IDLE:
                begin
                    if (!ssel_pipe[1])
                    begin
                        bit_cnt <= '0;
                        state   <= RX_SHIFT;
                    end
                end
                RX_SHIFT:
                begin
                    if (ssel_rise)
                    begin
                        // only an exact frame length counts
                        if (bit_cnt == BIT_CNT_W'(FRAME_BITS))
                        begin
                            rx_word     <= shreg;
                            frame_count <= frame_count + 1'b1;
                        end
                        state <= RX_IDLE;
                    end
                    else if (sck_rise)
                    begin
                        shreg <= {shreg[FRAME_BITS-2:0], mosi_pipe[1]};
                        // saturate so a long frame never wraps to good
                        if (bit_cnt != '1)
                            bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                default: state <= RX_IDLE;
            endcase

            // second latch on the sim tick
            if (sample_tick)
                rate <= rx_word;
        end
    end

endmodule

`default_nettype wire

//--- src/muscle_link_top.sv
`default_nettype none

module muscle_link_top import link_pkg::*; import regmap_pkg::*;
#(
    parameter int WAVE_DEPTH = 16
)
(
    input  wire logic       ep50trig,
    input  wire logic       reset_global,
    // wishbone classic slave
    input  wire logic       wb_cyc,
    input  wire logic       wb_stb,
    input  wire logic       wb_we,
    input  wire logic [2:0] wb_adr,
    input  wire data_word_t wb_wdata,
    output data_word_t      wb_rdata,
    output logic            wb_ack,
    // lengths out to the second board
    output logic            spi_out_sck,
    output logic            spi_out_mosi,
    output logic            spi_out_ssel,
    // rates back from the second board
    input  wire logic       spi_in_sck,
    input  wire logic       spi_in_mosi,
    input  wire logic       spi_in_ssel
);

    localparam int CNT_W = $clog2(WAVE_DEPTH + 1);

    logic                   sample_tick;
    data_word_t             length;
    data_word_t             rate;
    logic [CNT_W-1:0]       wave_count;
    logic [FRAME_CNT_W-1:0] frame_count;

    cfg_if u_cfg ();

    host_regs #(.WAVE_DEPTH(WAVE_DEPTH)) u_host_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (reg_addr_e'(wb_adr)),
        .wb_wdata     (wb_wdata),
        .wb_rdata     (wb_rdata),
        .wb_ack       (wb_ack),
        .length       (length),
        .rate         (rate),
        .wave_count   (wave_count),
        .frame_count  (frame_count),
        .cfg          (u_cfg.regs)
    );

    length_waveform #(.WAVE_DEPTH(WAVE_DEPTH)) u_length_waveform (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .cfg          (u_cfg.player),
        .sample_tick  (sample_tick),
        .length       (length),
        .wave_count   (wave_count)
    );

    spi_frame_tx u_spi_frame_tx (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .sample_tick  (sample_tick),
        .length       (length),
        .cfg          (u_cfg.serial),
        .sck          (spi_out_sck),
        .mosi         (spi_out_mosi),
        .ssel         (spi_out_ssel)
    );

    spi_frame_rx u_spi_frame_rx (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .sample_tick  (sample_tick),
        .sck          (spi_in_sck),
        .mosi         (spi_in_mosi),
        .ssel         (spi_in_ssel),
        .rate         (rate),
        .frame_count  (frame_count)
    );

endmodule

`default_nettype wire

//--- test/tb_muscle_link.sv
`default_nettype none

module tb_muscle_link import link_pkg::*; import regmap_pkg::*; ();

    //////////////////////////////
    // timing and sizes
    //////////////////////////////

    localparam int CLK_HALF      = 2;
    localparam int CLK_PERIOD    = 2 * CLK_HALF;
    localparam int RESET_CYCLES  = 4;
    localparam int WAVE_DEPTH    = 16;
    localparam int N_SAMPLES     = 5;
    // link settings used once running
    localparam int RUN_SCK_DIV   = 1;
    localparam int RUN_TICK_HALF = 199;
    localparam int TICK_CYCLES   = RUN_TICK_HALF + 1;
    localparam int FRAME_CYCLES  = 2 * FRAME_BITS * (RUN_SCK_DIV + 1) + 2;
    // frames captured over all tests
    localparam int N_FRAMES      = 17;
    // extra slots for bus traffic and the two hand driven frames
    localparam int SPARE_SLOTS   = 4;
    localparam int WATCHDOG_TIME =
        2 * (N_FRAMES + SPARE_SLOTS) * (TICK_CYCLES + FRAME_CYCLES) * CLK_PERIOD;
    localparam int ACK_LIMIT     = 8;
    localparam int SSEL_LIMIT    = 2 * TICK_CYCLES + FRAME_CYCLES;
    localparam int FRAME_LIMIT   = 2 * FRAME_CYCLES;
    // cycles per level of a hand driven sck
    localparam int SEND_HALF     = 4;
    // slave pin sync plus edge detect
    localparam int SYNC_CYCLES   = 4;

    logic       ep50trig;
    logic       reset_global;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [2:0] wb_adr;
    data_word_t wb_wdata;
    data_word_t wb_rdata;
    logic       wb_ack;
    logic       spi_out_sck;
    logic       spi_out_mosi;
    logic       spi_out_ssel;
    wire        spi_in_sck;
    wire        spi_in_mosi;
    wire        spi_in_ssel;

    // input pins hand driven or looped from the master
    logic       loop_en;
    logic       in_sck_drv;
    logic       in_mosi_drv;
    logic       in_ssel_drv;

    integer     seed;
    data_word_t samples [WAVE_DEPTH];
    int         table_len;
    int         play_idx;
    int         fc_exp;
    data_word_t exp_rate;

    assign spi_in_sck  = loop_en ? spi_out_sck  : in_sck_drv;
    assign spi_in_mosi = loop_en ? spi_out_mosi : in_mosi_drv;
    assign spi_in_ssel = loop_en ? spi_out_ssel : in_ssel_drv;

    muscle_link_top #(.WAVE_DEPTH(WAVE_DEPTH)) u_muscle_link_top (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_wdata     (wb_wdata),
        .wb_rdata     (wb_rdata),
        .wb_ack       (wb_ack),
        .spi_out_sck  (spi_out_sck),
        .spi_out_mosi (spi_out_mosi),
        .spi_out_ssel (spi_out_ssel),
        .spi_in_sck   (spi_in_sck),
        .spi_in_mosi  (spi_in_mosi),
        .spi_in_ssel  (spi_in_ssel)
    );

    always #CLK_HALF ep50trig = ~ep50trig;

    //////////////////////////////
    // failure and compare helpers
    //////////////////////////////

    task automatic fail_stop();
        $display("Done: errors found");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_pin(input string name, input logic actual, input logic expected);
        if (actual !== expected)
        begin
            $display("[FAIL] t=%0t %s expected %b actual %b", $time, name, expected, actual);
            fail_stop();
        end
    endtask

    task automatic check_frame(input int index, input data_word_t actual,
                               input data_word_t expected);
        if (actual !== expected)
        begin
            $display("[FAIL] t=%0t spi_out_mosi frame %0d expected %h actual %h",
                     $time, index, expected, actual);
            fail_stop();
        end
    endtask

    // good frames in bits 15..8 and samples in 7..0
    function automatic data_word_t status_word(input int frames, input int count);
        return data_word_t'(((frames & 8'hff) << 8) | (count & 8'hff));
    endfunction

    //////////////////////////////
    // wishbone master
    //////////////////////////////

    task automatic bus_cycle(input logic we, input reg_addr_e addr,
                             input data_word_t wdata, output data_word_t rdata);
        int waited;
        waited = 0;
        @(posedge ep50trig);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= addr;
        wb_wdata <= wdata;
        @(posedge ep50trig);
        // ack shows up one edge after the request is seen
        while (wb_ack !== 1'b1 && waited < ACK_LIMIT)
        begin
            @(posedge ep50trig);
            waited++;
        end
        if (wb_ack !== 1'b1)
        begin
            $display("bus timeout, no wb_ack for address %0d at t=%0t", addr, $time);
            fail_stop();
        end
        rdata = wb_rdata;
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input reg_addr_e addr, input data_word_t data);
        data_word_t unused;
        bus_cycle(1'b1, addr, data, unused);
    endtask

    task automatic wb_read(input reg_addr_e addr, output data_word_t data);
        bus_cycle(1'b0, addr, '0, data);
    endtask

    task automatic check_reg(input reg_addr_e addr, input data_word_t expected);
        data_word_t actual;
        wb_read(addr, actual);
        if (actual !== expected)
        begin
            $display("[FAIL] t=%0t wb_rdata at %s (addr %0d) expected %h actual %h",
                     $time, addr.name(), addr, expected, actual);
            fail_stop();
        end
    endtask

    //////////////////////////////
    // spi decode and drive
    //////////////////////////////

    // one frame off the output pins sampled on rising sck
    task automatic spi_capture(output data_word_t word);
        int   waited;
        int   bits;
        logic prev_sck;
        waited = 0;
        bits   = 0;
        word   = '0;
        @(posedge ep50trig);
        while (spi_out_ssel !== 1'b0 && waited < SSEL_LIMIT)
        begin
            @(posedge ep50trig);
            waited++;
        end
        if (spi_out_ssel !== 1'b0)
        begin
            $display("no spi frame started on the output pins by t=%0t", $time);
            fail_stop();
        end
        check_pin("spi_out_sck", spi_out_sck, 1'b0);
        waited   = 0;
        prev_sck = spi_out_sck;
        while (spi_out_ssel === 1'b0 && waited < FRAME_LIMIT)
        begin
            @(posedge ep50trig);
            waited++;
            if (spi_out_sck === 1'b1 && prev_sck === 1'b0)
            begin
                word = {word[FRAME_BITS-2:0], spi_out_mosi};
                bits++;
            end
            prev_sck = spi_out_sck;
        end
        if (spi_out_ssel !== 1'b1)
        begin
            $display("spi frame on the output pins never closed by t=%0t", $time);
            fail_stop();
        end
        if (bits != FRAME_BITS)
        begin
            $display("spi frame had %0d bits instead of %0d at t=%0t",
                     bits, FRAME_BITS, $time);
            fail_stop();
        end
        // ssel low for 64 sck levels plus two cycles
        if (waited != FRAME_CYCLES)
        begin
            $display("[FAIL] t=%0t spi_out_ssel low cycles expected %0d actual %0d",
                     $time, FRAME_CYCLES, waited);
            fail_stop();
        end
    endtask

    // mode 0 frame on the input pins with msb first and any bit count
    task automatic spi_send(input data_word_t value, input int nbits);
        int i;
        @(posedge ep50trig);
        in_ssel_drv <= 1'b0;
        in_sck_drv  <= 1'b0;
        in_mosi_drv <= 1'b0;
        repeat (SEND_HALF) @(posedge ep50trig);
        for (i = 0; i < nbits; i++)
        begin
            in_mosi_drv <= value[FRAME_BITS-1-i];
            repeat (SEND_HALF) @(posedge ep50trig);
            in_sck_drv <= 1'b1;
            repeat (SEND_HALF) @(posedge ep50trig);
            in_sck_drv <= 1'b0;
        end
        repeat (SEND_HALF) @(posedge ep50trig);
        in_ssel_drv <= 1'b1;
        in_mosi_drv <= 1'b0;
        // slave needs a few cycles to see ssel rise
        repeat (2 * SEND_HALF) @(posedge ep50trig);
    endtask

    // next frame must carry the next table entry
    task automatic check_next_sample();
        data_word_t got;
        spi_capture(got);
        check_frame(play_idx, got, samples[play_idx % table_len]);
        play_idx++;
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic reset_values();
        check_pin("wb_ack", wb_ack, 1'b0);
        check_pin("spi_out_sck", spi_out_sck, 1'b0);
        check_pin("spi_out_mosi", spi_out_mosi, 1'b0);
        check_pin("spi_out_ssel", spi_out_ssel, 1'b1);
        check_reg(REG_TICK_HALF, 32'd200);
        check_reg(REG_SCK_DIV, 32'd13);
        check_reg(REG_RATE_IN, '0);
        check_reg(REG_LEN_OUT, '0);
        check_reg(REG_STATUS, '0);
    endtask

    task automatic register_access();
        wb_write(REG_TICK_HALF, 32'h0000_1234);
        check_reg(REG_TICK_HALF, 32'h0000_1234);
        wb_write(REG_SCK_DIV, 32'h0000_0007);
        check_reg(REG_SCK_DIV, 32'h0000_0007);
        // address 7 has no register
        check_reg(reg_addr_e'(3'd7), '0);
        // rate is read only
        wb_write(REG_RATE_IN, 32'hdead_beef);
        check_reg(REG_RATE_IN, '0);
        wb_write(reg_addr_e'(3'd7), 32'hffff_ffff);
        check_reg(reg_addr_e'(3'd7), '0);
        // neither write lands in a writable register
        check_reg(REG_TICK_HALF, 32'h0000_1234);
        check_reg(REG_SCK_DIV, 32'h0000_0007);
        check_reg(REG_CTRL, '0);
    endtask

    task automatic sample_playback();
        int i;
        for (i = 0; i < N_SAMPLES; i++)
        begin
            samples[i] = $random(seed);
            wb_write(REG_WAVE_DATA, samples[i]);
        end
        table_len = N_SAMPLES;
        wb_write(REG_SCK_DIV, RUN_SCK_DIV);
        wb_write(REG_TICK_HALF, RUN_TICK_HALF);
        wb_write(REG_CTRL, data_word_t'(1) << CTRL_RUN_BIT);
        // two extra frames to see the wrap
        for (i = 0; i < N_SAMPLES + 2; i++)
            check_next_sample();
        check_reg(REG_STATUS, status_word(fc_exp, table_len));
        // length holds the sample of the last tick
        check_reg(REG_LEN_OUT, samples[(play_idx - 1) % table_len]);
    endtask

    task automatic loopback_rate();
        data_word_t sent [3];
        int         i;
        @(posedge ep50trig);
        loop_en <= 1'b1;
        for (i = 0; i < 3; i++)
        begin
            sent[i] = samples[play_idx % table_len];
            check_next_sample();
            fc_exp++;
        end
        repeat (SYNC_CYCLES) @(posedge ep50trig);
        check_reg(REG_STATUS, status_word(fc_exp, table_len));
        // last word still waits for its tick
        check_reg(REG_RATE_IN, sent[1]);
        @(posedge ep50trig);
        loop_en <= 1'b0;
        check_next_sample();
        exp_rate = sent[2];
        check_reg(REG_RATE_IN, exp_rate);
    endtask

    task automatic short_frame_reject();
        data_word_t junk;
        data_word_t good;
        junk = $random(seed);
        good = $random(seed);
        // stop before the next tick
        wb_write(REG_CTRL, '0);
        spi_send(junk, 20);
        check_reg(REG_STATUS, status_word(fc_exp, table_len));
        check_reg(REG_RATE_IN, exp_rate);
        spi_send(good, FRAME_BITS);
        fc_exp++;
        check_reg(REG_STATUS, status_word(fc_exp, table_len));
        // no tick yet so rate holds
        check_reg(REG_RATE_IN, exp_rate);
        wb_write(REG_CTRL, data_word_t'(1) << CTRL_RUN_BIT);
        check_next_sample();
        exp_rate = good;
        check_reg(REG_RATE_IN, exp_rate);
    endtask

    task automatic table_restart();
        data_word_t got;
        int         i;
        wb_write(REG_CTRL, (data_word_t'(1) << CTRL_RUN_BIT) |
                           (data_word_t'(1) << CTRL_RESTART_BIT));
        check_reg(REG_STATUS, status_word(fc_exp, 0));
        // empty table plays zero
        for (i = 0; i < 2; i++)
        begin
            spi_capture(got);
            check_frame(i, got, '0);
        end
        for (i = 0; i < 2; i++)
        begin
            samples[i] = $random(seed);
            wb_write(REG_WAVE_DATA, samples[i]);
        end
        table_len = 2;
        play_idx  = 0;
        check_reg(REG_STATUS, status_word(fc_exp, table_len));
        for (i = 0; i < 3; i++)
            check_next_sample();
    endtask

    //////////////////////////////
    // run control
    //////////////////////////////

    initial
    begin
        #(WATCHDOG_TIME);
        $display("watchdog expired at t=%0t, the tests did not finish", $time);
        fail_stop();
    end

    initial
    begin
        seed         = 80;
        ep50trig     = 1'b0;
        reset_global = 1'b1;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_wdata     = '0;
        loop_en      = 1'b0;
        in_sck_drv   = 1'b0;
        in_mosi_drv  = 1'b0;
        in_ssel_drv  = 1'b1;
        table_len    = 0;
        play_idx     = 0;
        fc_exp       = 0;
        exp_rate     = '0;
        repeat (RESET_CYCLES) @(posedge ep50trig);
        reset_global <= 1'b0;

        reset_values();
        register_access();
        sample_playback();
        loopback_rate();
        short_frame_reject();
        table_restart();

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
src/link_pkg.sv
src/regmap_pkg.sv
src/cfg_if.sv
src/host_regs.sv
src/length_waveform.sv
src/spi_frame_tx.sv
src/spi_frame_rx.sv
src/muscle_link_top.sv
test/tb_muscle_link.sv

//--- Makefile
TOP := tb_muscle_link

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -Wno-fatal --top-module $(TOP) -f filelist.f

run: build
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir sim.log
